//--- Makefile
# Verilator build and run for the fetch-to-decode prediction stage.

VERILATOR ?= verilator
TOP       ?= tb_fetch_predict
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS PASS_MSG"

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bp_pkg.sv
// Branch predictor package.
// Encoding of the 2-bit saturating direction counter, the default
// table depth and the state that a never-written entry reads as.

package bp_pkg;

        // Direction counter states.
        typedef enum logic [1:0]
        {
                bp_snt = 2'd0,  // Strongly not taken.
                bp_wnt = 2'd1,  // Weakly not taken.
                bp_wt  = 2'd2,  // Weakly taken.
                bp_st  = 2'd3   // Strongly taken.
        } bp_state_t;

        // Default table depth.
        // Must be a power of two.
        localparam int unsigned bp_entries_default = 512;

        // State of an entry before its first write.
        localparam bp_state_t bp_init_state = bp_wnt;

endpackage

//--- branch_predict_ram.sv
// Branch predictor state table.
// Direct-mapped array of 2-bit direction states with one
// synchronous read port and one write port. A valid bit per
// entry lets reset empty the table in a single cycle, so entries
// that were never written read as the initial state.

module branch_predict_ram
        import bp_pkg::*;
#(
        parameter  int unsigned NUMBER_OF_ENTRIES = 512,
        localparam int unsigned addr_width        = $clog2(NUMBER_OF_ENTRIES)
)
(
        input  logic                  i_clk,
        input  logic                  i_reset,

        // Write port.
        input  logic                  i_wr_en,
        input  logic [addr_width-1:0] i_wr_addr,
        input  bp_state_t             i_wr_data,

        // Read port.
        input  logic                  i_rd_en,
        input  logic [addr_width-1:0] i_rd_addr,
        output bp_state_t             o_rd_data
);

        // State storage.
        bp_state_t mem [NUMBER_OF_ENTRIES];

        // One bit per entry, set on the first write.
        logic [NUMBER_OF_ENTRIES-1:0] entry_valid;

        // Word seen by the read port before the edge.
        bp_state_t rd_word;

        always_comb
        begin
                if (entry_valid[i_rd_addr])
                begin
                        rd_word = mem[i_rd_addr];
                end
                else
                begin
                        rd_word = bp_init_state;
                end
        end

        // Array write.
        always_ff @(posedge i_clk)
        begin
                if (i_wr_en)
                begin
                        mem[i_wr_addr] <= i_wr_data;
                end
        end

        // Valid bits, all cleared together on reset.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        entry_valid <= '0;
                end
                else if (i_wr_en)
                begin
                        entry_valid[i_wr_addr] <= 1'b1;
                end
        end

        // Registered read; returns the old word on a same-index write.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_rd_data <= bp_init_state;
                end
                else if (i_rd_en)
                begin
                        o_rd_data <= rd_word;
                end
        end

endmodule

//--- branch_predict_stage.sv
// Branch prediction stage.
// Fetch-to-decode pipeline register with fixed clear and stall
// priority. Looks up the direction state of the fetched PC and
// writes back corrected or strengthened states sent by the ALU.

module branch_predict_stage
        import pipe_pkg::*;
        import bp_pkg::*;
#(
        parameter int unsigned BP_ENTRIES = bp_entries_default
)
(
        input  logic                  i_clk,
        input  logic                  i_reset,

        // Clears and stalls, highest priority first.
        input  logic                  i_clear_from_writeback,
        input  logic                  i_data_stall,
        input  logic                  i_clear_from_alu,
        input  logic                  i_stall_from_shifter,
        input  logic                  i_stall_from_issue,
        input  logic                  i_stall_from_decode,
        input  logic                  i_clear_from_decode,

        // Resolved branch from the ALU.
        input  logic                  i_confirm_from_alu,
        input  logic [data_width-1:0] i_pc_from_alu,
        input  bp_state_t             i_taken,

        // From fetch.
        input  logic [data_width-1:0] i_pc,
        input  logic [data_width-1:0] i_inst,
        input  logic                  i_val,
        input  logic                  i_abt,
        input  logic [data_width-1:0] i_pc_plus_8,

        // To decode.
        output logic [data_width-1:0] o_inst_ff,
        output logic                  o_val_ff,
        output logic                  o_abt_ff,
        output logic [data_width-1:0] o_pc_ff,
        output logic [data_width-1:0] o_pc_plus_8_ff,
        output bp_state_t             o_taken_ff
);

        localparam int unsigned idx_width = $clog2(BP_ENTRIES);

        // What the stage register does at the next edge.
        typedef enum logic [1:0]
        {
                act_advance,
                act_hold,
                act_flush
        } stage_act_t;

        stage_act_t           stage_act;
        logic                 rd_en;
        logic                 wr_en;
        bp_state_t            wr_data;
        logic [idx_width-1:0] rd_index;
        logic [idx_width-1:0] wr_index;

        // Saturating counter update.
        // A mispredict moves one step toward the other direction.
        function automatic bp_state_t update_state(input bp_state_t taken,
                                                   input logic mispredict);
                bp_state_t result;
                result = taken;
                if (mispredict)
                begin
                        case (taken)
                        bp_snt: result = bp_wnt;
                        bp_wnt: result = bp_wt;
                        bp_wt:  result = bp_wnt;
                        bp_st:  result = bp_wt;
                        endcase
                end
                else
                begin
                        case (taken)
                        bp_snt: result = bp_snt;
                        bp_wnt: result = bp_snt;
                        bp_wt:  result = bp_st;
                        bp_st:  result = bp_st;
                        endcase
                end
                return result;
        endfunction

        // Fixed priority over clears and stalls.
        always_comb
        begin
                if (i_clear_from_writeback)
                        stage_act = act_flush;
                else if (i_data_stall)
                        stage_act = act_hold;
                else if (i_clear_from_alu)
                        stage_act = act_flush;
                else if (i_stall_from_shifter || i_stall_from_issue || i_stall_from_decode)
                        stage_act = act_hold;
                else if (i_clear_from_decode)
                        stage_act = act_flush;
                else
                        stage_act = act_advance;
        end

        // Stage register; reset leaves it flushed.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || (stage_act == act_flush))
                begin
                        o_inst_ff      <= '0;
                        o_val_ff       <= 1'b0;
                        o_abt_ff       <= 1'b0;
                        o_pc_ff        <= '0;
                        o_pc_plus_8_ff <= flush_pc_plus_8;
                end
                else if (stage_act == act_advance)
                begin
                        o_inst_ff      <= i_inst;
                        o_val_ff       <= i_val;
                        o_abt_ff       <= i_abt;
                        o_pc_ff        <= i_pc;
                        o_pc_plus_8_ff <= i_pc_plus_8;
                end
        end

        // Table indexes skip the halfword bit.
        assign rd_index = i_pc[idx_width:1];
        assign wr_index = i_pc_from_alu[idx_width:1];

        // Prediction moves only with its instruction.
        assign rd_en   = (stage_act == act_advance);
        assign wr_en   = !i_data_stall && (i_clear_from_alu || i_confirm_from_alu);
        assign wr_data = update_state(i_taken, i_clear_from_alu);

        branch_predict_ram #(
                .NUMBER_OF_ENTRIES (BP_ENTRIES)
        ) u_br_ram (
                .i_clk     (i_clk),
                .i_reset   (i_reset),
                .i_wr_en   (wr_en),
                .i_wr_addr (wr_index),
                .i_wr_data (wr_data),
                .i_rd_en   (rd_en),
                .i_rd_addr (rd_index),
                .o_rd_data (o_taken_ff)
        );

endmodule

//--- fetch_predict_checker.sv
// Fetch-to-decode prediction checker.
// Bound to the top level. Keeps a model of the stage register and
// a shadow copy of the predictor table, and compares every output
// with it through concurrent assertions.

module fetch_predict_checker
        import pipe_pkg::*;
        import bp_pkg::*;
#(
        parameter int unsigned BP_ENTRIES = bp_entries_default
)
(
        input logic                  i_clk,
        input logic                  i_reset,
        input logic                  i_clear_from_writeback,
        input logic                  i_data_stall,
        input logic                  i_clear_from_alu,
        input logic                  i_stall_from_shifter,
        input logic                  i_stall_from_issue,
        input logic                  i_stall_from_decode,
        input logic                  i_clear_from_decode,
        input logic                  i_confirm_from_alu,
        input logic [data_width-1:0] i_pc_from_alu,
        input bp_state_t             i_taken,
        input logic [data_width-1:0] i_pc,
        input logic [data_width-1:0] i_inst,
        input logic                  i_val,
        input logic                  i_abt,
        input logic [data_width-1:0] i_pc_plus_8,
        input logic [data_width-1:0] o_inst_ff,
        input logic                  o_val_ff,
        input logic                  o_abt_ff,
        input logic [data_width-1:0] o_pc_ff,
        input logic [data_width-1:0] o_pc_plus_8_ff,
        input bp_state_t             o_taken_ff
);
        timeunit 1ns;
        timeprecision 1ps;

        localparam int unsigned idx_width = $clog2(BP_ENTRIES);

        typedef enum logic [1:0]
        {
                op_advance,
                op_hold,
                op_flush
        } stage_op_t;

        stage_op_t             op;
        logic                  was_held;
        logic [data_width-1:0] exp_inst, exp_pc, exp_pc_plus_8;
        logic [1:0]            exp_flags;
        bp_state_t             exp_taken, prev_taken;
        bp_state_t             shadow [BP_ENTRIES];
        int unsigned           error_count = 0;

        // Counter after a resolved branch.
        function automatic bp_state_t next_state(input bp_state_t s, input logic wrong);
                if (!wrong)
                        return s[1] ? bp_st : bp_snt;
                if (s == bp_snt || s == bp_wt)
                        return bp_wnt;
                return bp_wt;
        endfunction

        // Later lines win, so the last test is the highest priority.
        always_comb
        begin
                op = op_advance;
                if (i_clear_from_decode)
                        op = op_flush;
                if (i_stall_from_shifter || i_stall_from_issue || i_stall_from_decode)
                        op = op_hold;
                if (i_clear_from_alu)
                        op = op_flush;
                if (i_data_stall)
                        op = op_hold;
                if (i_clear_from_writeback)
                        op = op_flush;
        end

        // Reference model of the stage and the table.
        always @(posedge i_clk)
        begin
                prev_taken <= o_taken_ff;
                if (i_reset)
                begin
                        was_held      <= 1'b0;
                        exp_inst      <= '0;
                        exp_flags     <= 2'b00;
                        exp_pc        <= '0;
                        exp_pc_plus_8 <= flush_pc_plus_8;
                        exp_taken     <= bp_init_state;
                        shadow        <= '{default: bp_init_state};
                end
                else
                begin
                        was_held <= (op == op_hold);
                        if (op == op_flush)
                        begin
                                exp_inst      <= '0;
                                exp_flags     <= 2'b00;
                                exp_pc        <= '0;
                                exp_pc_plus_8 <= flush_pc_plus_8;
                        end
                        else if (op == op_advance)
                        begin
                                exp_inst      <= i_inst;
                                exp_flags     <= {i_val, i_abt};
                                exp_pc        <= i_pc;
                                exp_pc_plus_8 <= i_pc_plus_8;
                                exp_taken     <= shadow[i_pc[idx_width:1]];
                        end
                        // Data stall blocks the table write.
                        if (!i_data_stall && (i_clear_from_alu || i_confirm_from_alu))
                                shadow[i_pc_from_alu[idx_width:1]] <= next_state(i_taken,
                                                                          i_clear_from_alu);
                end
        end

        a_reset: assert property (@(posedge i_clk) $fell(i_reset) |->
                        !o_val_ff && !o_abt_ff && o_pc_plus_8_ff == flush_pc_plus_8 &&
                        o_taken_ff == bp_init_state)
        else
        begin
                error_count++;
                $error({"[ERROR] reset o_val_ff %h o_abt_ff %h o_pc_plus_8_ff %h",
                        " o_taken_ff %h expected 0 0 %h %h"},
                       $sampled(o_val_ff), $sampled(o_abt_ff), $sampled(o_pc_plus_8_ff),
                       $sampled(o_taken_ff), flush_pc_plus_8, bp_init_state);
        end

        a_inst: assert property (@(posedge i_clk) disable iff (i_reset)
                        o_inst_ff == exp_inst)
        else
        begin
                error_count++;
                $error("[ERROR] o_inst_ff expected %h actual %h",
                       $sampled(exp_inst), $sampled(o_inst_ff));
        end

        a_flags: assert property (@(posedge i_clk) disable iff (i_reset)
                        {o_val_ff, o_abt_ff} == exp_flags)
        else
        begin
                error_count++;
                $error("[ERROR] {o_val_ff,o_abt_ff} expected %h actual %h",
                       $sampled(exp_flags), $sampled({o_val_ff, o_abt_ff}));
        end

        a_pc: assert property (@(posedge i_clk) disable iff (i_reset)
                        o_pc_ff == exp_pc)
        else
        begin
                error_count++;
                $error("[ERROR] o_pc_ff expected %h actual %h",
                       $sampled(exp_pc), $sampled(o_pc_ff));
        end

        a_pc_plus_8: assert property (@(posedge i_clk) disable iff (i_reset)
                        o_pc_plus_8_ff == exp_pc_plus_8)
        else
        begin
                error_count++;
                $error("[ERROR] o_pc_plus_8_ff expected %h actual %h",
                       $sampled(exp_pc_plus_8), $sampled(o_pc_plus_8_ff));
        end

        a_taken: assert property (@(posedge i_clk) disable iff (i_reset)
                        o_taken_ff == exp_taken)
        else
        begin
                error_count++;
                $error("[ERROR] o_taken_ff expected %h actual %h",
                       $sampled(exp_taken), $sampled(o_taken_ff));
        end

        // Prediction is frozen while the stage holds.
        a_taken_hold: assert property (@(posedge i_clk) disable iff (i_reset)
                        was_held |-> o_taken_ff == prev_taken)
        else
        begin
                error_count++;
                $error("[ERROR] o_taken_ff held expected %h actual %h",
                       $sampled(prev_taken), $sampled(o_taken_ff));
        end

endmodule

//--- fetch_predict_top.sv
// Fetch-to-decode prediction top level.
// Sets the predictor table depth and wires the branch
// prediction stage to the surrounding pipeline.

module fetch_predict_top
        import pipe_pkg::*;
        import bp_pkg::*;
#(
        parameter int unsigned BP_ENTRIES = bp_entries_default
)
(
        input  logic                  i_clk,
        input  logic                  i_reset,

        // Clears and stalls, highest priority first.
        input  logic                  i_clear_from_writeback,
        input  logic                  i_data_stall,
        input  logic                  i_clear_from_alu,
        input  logic                  i_stall_from_shifter,
        input  logic                  i_stall_from_issue,
        input  logic                  i_stall_from_decode,
        input  logic                  i_clear_from_decode,

        // Branch resolution from the ALU.
        input  logic                  i_confirm_from_alu,
        input  logic [data_width-1:0] i_pc_from_alu,
        input  bp_state_t             i_taken,

        // Fetched instruction.
        input  logic [data_width-1:0] i_pc,
        input  logic [data_width-1:0] i_inst,
        input  logic                  i_val,
        input  logic                  i_abt,
        input  logic [data_width-1:0] i_pc_plus_8,

        // Registered stage outputs.
        output logic [data_width-1:0] o_inst_ff,
        output logic                  o_val_ff,
        output logic                  o_abt_ff,
        output logic [data_width-1:0] o_pc_ff,
        output logic [data_width-1:0] o_pc_plus_8_ff,
        output bp_state_t             o_taken_ff
);

        branch_predict_stage #(
                .BP_ENTRIES (BP_ENTRIES)
        ) u_stage (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear_from_writeback (i_clear_from_writeback),
                .i_data_stall           (i_data_stall),
                .i_clear_from_alu       (i_clear_from_alu),
                .i_stall_from_shifter   (i_stall_from_shifter),
                .i_stall_from_issue     (i_stall_from_issue),
                .i_stall_from_decode    (i_stall_from_decode),
                .i_clear_from_decode    (i_clear_from_decode),
                .i_confirm_from_alu     (i_confirm_from_alu),
                .i_pc_from_alu          (i_pc_from_alu),
                .i_taken                (i_taken),
                .i_pc                   (i_pc),
                .i_inst                 (i_inst),
                .i_val                  (i_val),
                .i_abt                  (i_abt),
                .i_pc_plus_8            (i_pc_plus_8),
                .o_inst_ff              (o_inst_ff),
                .o_val_ff               (o_val_ff),
                .o_abt_ff               (o_abt_ff),
                .o_pc_ff                (o_pc_ff),
                .o_pc_plus_8_ff         (o_pc_plus_8_ff),
                .o_taken_ff             (o_taken_ff)
        );

endmodule

//--- pipe_pkg.sv
// Pipeline word package.
// Width of instruction and PC words, and the values that an
// empty fetch-to-decode stage holds after a flush or a reset.

package pipe_pkg;

        // Width of instruction and PC words.
        localparam int unsigned data_width = 32;

        // PC plus 8 of an empty stage.
        // It matches a PC of zero, as the pipeline sees it.
        localparam logic [data_width-1:0] flush_pc_plus_8 = 32'd8;

endpackage

//--- sources.f
pipe_pkg.sv
bp_pkg.sv
branch_predict_ram.sv
branch_predict_stage.sv
fetch_predict_top.sv
fetch_predict_checker.sv
tb_fetch_predict.sv

//--- tb_fetch_predict.sv
// Testbench for the fetch-to-decode prediction stage.
// Runs directed clear and stall pairs, repeated counter updates
// on one table index, then random traffic. The bound checker
// compares every output against its own model.

module tb_fetch_predict
        import pipe_pkg::*;
        import bp_pkg::*;
();
        timeunit 1ns;
        timeprecision 1ps;

        localparam int unsigned bp_entries    = 16;
        localparam int unsigned random_cycles = 2000;
        localparam int unsigned cycle_limit   = 3000;

        // Branch PC used by the counter phase.
        localparam logic [data_width-1:0] hot_pc = 32'h0000_0124;

        logic                  i_clk = 1'b0;
        logic                  i_reset;
        logic                  i_clear_from_writeback;
        logic                  i_data_stall;
        logic                  i_clear_from_alu;
        logic                  i_stall_from_shifter;
        logic                  i_stall_from_issue;
        logic                  i_stall_from_decode;
        logic                  i_clear_from_decode;
        logic                  i_confirm_from_alu;
        logic [data_width-1:0] i_pc_from_alu;
        bp_state_t             i_taken;
        logic [data_width-1:0] i_pc;
        logic [data_width-1:0] i_inst;
        logic                  i_val;
        logic                  i_abt;
        logic [data_width-1:0] i_pc_plus_8;
        logic [data_width-1:0] o_inst_ff;
        logic                  o_val_ff;
        logic                  o_abt_ff;
        logic [data_width-1:0] o_pc_ff;
        logic [data_width-1:0] o_pc_plus_8_ff;
        bp_state_t             o_taken_ff;
        int unsigned           cycle_count = 0;

        fetch_predict_top #(
                .BP_ENTRIES (bp_entries)
        ) i_dut (.*);

        bind fetch_predict_top fetch_predict_checker #(
                .BP_ENTRIES (BP_ENTRIES)
        ) u_checker (.*);

        always #50 i_clk = ~i_clk;

        task automatic abort_run(input string reason);
                $display("%s", reason);
                $display("Simulation FAILED");
                $fatal(1);
        endtask

        // Bit 6 is the writeback clear, bit 0 the decode clear.
        task automatic set_controls(input logic [6:0] ctl);
                i_clear_from_writeback <= ctl[6];
                i_data_stall           <= ctl[5];
                i_clear_from_alu       <= ctl[4];
                i_stall_from_shifter   <= ctl[3];
                i_stall_from_issue     <= ctl[2];
                i_stall_from_decode    <= ctl[1];
                i_clear_from_decode    <= ctl[0];
        endtask

        task automatic fetch_random(input logic [data_width-1:0] pc);
                i_pc        <= pc;
                i_inst      <= $urandom;
                i_val       <= 1'($urandom);
                i_abt       <= 1'($urandom);
                i_pc_plus_8 <= pc + 32'd8;
        endtask

        task automatic alu_resolve(input logic confirm, input logic [data_width-1:0] pc,
                                   input bp_state_t taken);
                i_confirm_from_alu <= confirm;
                i_pc_from_alu      <= pc;
                i_taken            <= taken;
        endtask

        task automatic quiet_cycle(input logic [data_width-1:0] pc);
                @(posedge i_clk);
                set_controls(7'd0);
                fetch_random(pc);
                alu_resolve(1'b0, '0, bp_snt);
        endtask

        // Every pair of clears and stalls, singles included.
        task automatic priority_pairs();
                logic [6:0]  ctl;
                int unsigned hi;
                int unsigned lo;
                for (hi = 0; hi < 7; hi++)
                        for (lo = hi; lo < 7; lo++)
                        begin
                                ctl = (7'd1 << hi) | (7'd1 << lo);
                                @(posedge i_clk);
                                set_controls(ctl);
                                fetch_random($urandom);
                                alu_resolve(1'($urandom), $urandom, bp_state_t'(2'($urandom)));
                                quiet_cycle($urandom);
                        end
        endtask

        // Confirms and mispredicts from every state on one index.
        task automatic hammer_one_index();
                int unsigned s;
                int unsigned kind;
                for (s = 0; s < 4; s++)
                        for (kind = 0; kind < 4; kind++)
                        begin
                                // Bit 0 picks a mispredict, bit 1 adds a data stall.
                                @(posedge i_clk);
                                set_controls({1'b0, kind[1], kind[0], 4'b0000});
                                fetch_random(hot_pc);
                                alu_resolve(!kind[0], hot_pc, bp_state_t'(s[1:0]));
                                quiet_cycle(hot_pc);
                        end
        endtask

        task automatic random_cycle();
                logic [6:0]  ctl;
                int unsigned i;
                ctl = 7'd0;
                for (i = 0; i < 7; i++)
                        ctl = {ctl[5:0], (($urandom % 10) == 0)};
                @(posedge i_clk);
                set_controls(ctl);
                fetch_random($urandom);
                alu_resolve((($urandom % 5) == 0), $urandom, bp_state_t'(2'($urandom)));
        endtask

        always @(posedge i_clk)
        begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= cycle_limit)
                        abort_run($sformatf("Timeout: run did not finish in %0d cycles",
                                            cycle_limit));
        end

        // Assertions of a rising edge have reported by the falling edge.
        always @(negedge i_clk)
        begin
                if (i_dut.u_checker.error_count != 0)
                        abort_run("A checker assertion failed");
        end

        initial
        begin
                void'($urandom(17068));
                i_reset <= 1'b1;
                set_controls(7'd0);
                fetch_random('0);
                alu_resolve(1'b0, '0, bp_snt);
                repeat (8) @(posedge i_clk);
                i_reset <= 1'b0;

                priority_pairs();
                hammer_one_index();
                repeat (random_cycles) random_cycle();

                quiet_cycle('0);
                repeat (3) @(posedge i_clk);
                if (i_dut.u_checker.error_count == 0)
                begin
                        $display("Simulation PASSED");
                        $finish;
                end
                else
                        abort_run("Checker assertions failed during the run");
        end

endmodule
